//--- serialStim.mem
// opcode argument data: 01 send, 02 sdramReady, 03 idle cycles, 04 write addr/data,
// 05 tx char (argument 1 waits for previous reply), 06 error hold, 07 nibbleSel, ff end
// Three byte write from 1ABCDE
0500000141 0500000043 050000004b 050000000d 050000000a 041abcde11 041abcdf22 041abce033
0100000057 0100000030 0100000032 010000002c 0100000031 0100000041 0100000062 0100000043
0100000044 0100000045 010000002c 0100000031 0100000031 0100000032 0100000032 0100000033
0100000033 010000000d 010000000a
// Nibble select high, then low
0500000141 0500000043 050000004b 050000000d 050000000a 0100000053 0100000031 010000000d
010000000a 0700000001
0500000141 0500000043 050000004b 050000000d 050000000a 0100000053 0100000030 010000000a
010000000a 0700000000
// Ready query, high then low
0200000001 0500000159 050000000d 050000000a 0100000059 010000000d 010000000a
0200000000 050000014e 050000000d 050000000a 0100000059 010000000d 010000000a
// Unknown letter, then characters sent during the error hold
050000014e 0500000041 050000004b 050000000d 050000000a 0100000051 0600000000
0100000059 010000000d 010000000a
// Non-hex digit inside a write
050000014e 0500000041 050000004b 050000000d 050000000a 0100000057 0100000030 0100000047
0600000000
// Write stalled in its address field, then a valid write
050000014e 0500000041 050000004b 050000000d 050000000a 0100000057 0100000030 0100000030
010000002c 0100000031 0100000041 0300000064 0600000000
0500000141 0500000043 050000004b 050000000d 050000000a 040000105a 0100000057 0100000030
0100000030 010000002c 0100000030 0100000030 0100000030 0100000030 0100000031 0100000030
010000002c 0100000035 0100000061 010000000d 010000000a
ff00000000

//--- sim.f
sdramTestPkg.sv
cmdParser.sv
commsWatchdog.sv
replySequencer.sv
serialProtocol.sv
tbSerialProtocol.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the serial protocol testbench with Verilator
cd "$(dirname "$0")" || exit 1
if ! verilator --binary --assert -Wno-fatal --top-module tbSerialProtocol -f sim.f; then
   echo "Verilator build failed"
   exit 1
fi
if ! ./obj_dir/VtbSerialProtocol; then
   echo "Simulation reported failure"
   exit 1
fi
exit 0

//--- tbSerialProtocol.sv
// Serial protocol testbench
module tbSerialProtocol
   import sdramTestPkg::*;
();

   localparam int TimeoutCycles   = 64;
   localparam int ErrorHoldCycles = 40;
   localparam int StimDepth       = 256;

   localparam logic [7:0] OpSend   = 8'h01;
   localparam logic [7:0] OpReady  = 8'h02;
   localparam logic [7:0] OpIdle   = 8'h03;
   localparam logic [7:0] OpWrite  = 8'h04;
   localparam logic [7:0] OpChar   = 8'h05;
   localparam logic [7:0] OpHold   = 8'h06;
   localparam logic [7:0] OpNibble = 8'h07;
   localparam logic [7:0] OpEnd    = 8'hff;

   logic      clk        = 1'b0;
   logic      rst        = 1'b1;
   logic      rxValid    = 1'b0;
   charT      rxData     = '0;
   logic      txActive   = 1'b0;
   logic      sdramReady = 1'b0;
   charT      txData;
   logic      txStart;
   logic      writeStrobe;
   sdramAddrT sdramAddr;
   dataByteT  writeData;
   logic      nibbleSel;
   logic      serialError;

   logic [39:0] stim [0:StimDepth-1];
   charT        charQ [$];
   sdramAddrT   addrQ [$];
   dataByteT    dataQ [$];

   int   gapSeed      = 32'hd71c10f9;
   int   uartSeed     = 32'hd71c10f9;
   int   activeLeft   = 0;
   int   cycleCount   = 0;
   int   cycleLimit   = 0;
   int   handoffCycle = 0;
   int   holdLength   = 0;
   int   holdsStarted = 0;
   int   holdsClaimed = 0;
   logic prevTxStart  = 1'b0;
   logic prevError    = 1'b0;

   always #5 clk = ~clk;

   serialProtocol #(
      .TimeoutCycles   (TimeoutCycles),
      .ErrorHoldCycles (ErrorHoldCycles)
   ) serialProtocol_inst (
      .clk         (clk),
      .rst         (rst),
      .rxValid     (rxValid),
      .rxData      (rxData),
      .txData      (txData),
      .txStart     (txStart),
      .txActive    (txActive),
      .writeStrobe (writeStrobe),
      .sdramAddr   (sdramAddr),
      .writeData   (writeData),
      .nibbleSel   (nibbleSel),
      .sdramReady  (sdramReady),
      .serialError (serialError)
   );

   task automatic stopWithFailure();
      $display("Testbench failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic reportProblem(string what);
      $display("%0t %s", $time, what);
      stopWithFailure();
   endtask

   task automatic checkChar(charT got, charT expected);
      if (got !== expected)
      begin
         $display("[FAIL] %0t txData got %h expected %h", $time, got, expected);
         stopWithFailure();
      end
   endtask

   task automatic checkWrite(sdramAddrT gotAddr, dataByteT gotData,
                             sdramAddrT expAddr, dataByteT expData);
      if (gotAddr !== expAddr)
      begin
         $display("[FAIL] %0t sdramAddr got %h expected %h", $time, gotAddr, expAddr);
         stopWithFailure();
      end
      if (gotData !== expData)
      begin
         $display("[FAIL] %0t writeData got %h expected %h", $time, gotData, expData);
         stopWithFailure();
      end
   endtask

   task automatic checkLevel(string name, logic got, logic expected);
      if (got !== expected)
      begin
         $display("[FAIL] %0t %s got %b expected %b", $time, name, got, expected);
         stopWithFailure();
      end
   endtask

   task automatic checkHoldLength(int got);
      if (got != ErrorHoldCycles)
      begin
         $display("[FAIL] %0t serialError cycles got %0d expected %0d",
                  $time, got, ErrorHoldCycles);
         stopWithFailure();
      end
   endtask

   // Previous reply fully sent and any error hold over
   task automatic waitReplyDone();
      while (charQ.size() != 0 || txStart || serialError)
         @(posedge clk);
   endtask

   task automatic waitHoldStart();
      while (holdsStarted == holdsClaimed)
         @(posedge clk);
      holdsClaimed++;
   endtask

   task automatic sendChar(charT c);
      int gap;
      gap = 1 + ($unsigned($random(gapSeed)) % 4);
      @(posedge clk);
      rxValid <= 1'b1;
      rxData  <= c;
      @(posedge clk);
      rxValid <= 1'b0;
      repeat (gap - 1) @(posedge clk);
   endtask

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleLimit > 0 && cycleCount >= cycleLimit)
         reportProblem("Run did not finish within the cycle limit");
   end

   // UART transmitter model
   always @(posedge clk)
   begin
      if (rst)
      begin
         txActive   <= 1'b0;
         activeLeft <= 0;
      end
      else if (txActive)
      begin
         activeLeft <= activeLeft - 1;
         if (activeLeft == 1)
            txActive <= 1'b0;
      end
      else if (txStart)
      begin
         txActive   <= 1'b1;
         activeLeft <= 2 + ($unsigned($random(uartSeed)) % 5);
      end
   end

   // Transmit, write and error hold monitor
   always @(posedge clk)
   begin
      if (!rst)
      begin
         if (txStart && !prevTxStart)
         begin
            if (charQ.size() == 0)
               reportProblem($sformatf("Unexpected character %h transmitted", txData));
            else
               checkChar(txData, charQ.pop_front());
         end
         if (txStart && txActive)
            handoffCycle <= cycleCount;
         if (writeStrobe)
         begin
            if (addrQ.size() == 0)
               reportProblem($sformatf("Unexpected write of %h to %h", writeData, sdramAddr));
            else
               checkWrite(sdramAddr, writeData, addrQ.pop_front(), dataQ.pop_front());
         end
         if (serialError && !prevError)
         begin
            if (cycleCount != handoffCycle + 1)
               reportProblem("Error hold did not start right after the LF handoff");
            holdLength   <= 1;
            holdsStarted <= holdsStarted + 1;
         end
         else if (serialError)
            holdLength <= holdLength + 1;
         else if (prevError)
            checkHoldLength(holdLength);
      end
      prevTxStart <= txStart;
      prevError   <= serialError;
   end

   // Stimulus player
   initial
   begin
      int          recordCount;
      int          idleSum;
      int          i;
      logic [7:0]  op;
      logic [23:0] arg;
      logic [7:0]  data;
      $readmemh("serialStim.mem", stim);
      recordCount = 0;
      idleSum     = 0;
      while (recordCount < StimDepth && stim[recordCount][39:32] !== OpEnd)
      begin
         if (stim[recordCount][39:32] == OpIdle)
            idleSum += int'(stim[recordCount][31:8]);
         recordCount++;
      end
      if (recordCount == StimDepth)
         reportProblem("Stimulus file has no end record");
      cycleLimit = (recordCount + 1) * 300 + idleSum;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      for (i = 0; i < recordCount; i++)
      begin
         op   = stim[i][39:32];
         arg  = stim[i][31:8];
         data = stim[i][7:0];
         case (op)
            OpSend:
               sendChar(data);
            OpReady:
            begin
               waitReplyDone();
               sdramReady <= data[0];
            end
            OpIdle:
               repeat (arg) @(posedge clk);
            OpWrite:
            begin
               addrQ.push_back(arg[20:0]);
               dataQ.push_back(data);
            end
            OpChar:
            begin
               if (arg[0])
                  waitReplyDone();
               charQ.push_back(data);
            end
            OpHold:
               waitHoldStart();
            OpNibble:
            begin
               waitReplyDone();
               checkLevel("nibbleSel", nibbleSel, data[0]);
            end
            default:
               reportProblem($sformatf("Unknown opcode %h in record %0d", op, i));
         endcase
      end
      waitReplyDone();
      repeat (2) @(posedge clk);
      if (addrQ.size() == 0 && holdsStarted == holdsClaimed)
      begin
         $display("Testbench passed");
         $finish;
      end
      else
         reportProblem("Listed writes or error holds did not match what the DUT did");
   end

endmodule

//--- serialProtocol.sv
// Serial command front end
module serialProtocol
   import sdramTestPkg::*;
#(
   parameter int TimeoutCycles   = 64,
   parameter int ErrorHoldCycles = 40
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      rxValid,
   input  charT      rxData,
   output charT      txData,
   output logic      txStart,
   input  logic      txActive,
   output logic      writeStrobe,
   output sdramAddrT sdramAddr,
   output dataByteT  writeData,
   output logic      nibbleSel,
   input  logic      sdramReady,
   output logic      serialError
);

   logic    cmdOpen;
   logic    outcomeValid;
   outcomeT outcomeKind;
   logic    timeout;
   logic    replyBusy;

   cmdParser cmdParser_inst (
      .clk          (clk),
      .rst          (rst),
      .rxValid      (rxValid),
      .rxData       (rxData),
      .replyBusy    (replyBusy),
      .timeout      (timeout),
      .cmdOpen      (cmdOpen),
      .outcomeValid (outcomeValid),
      .outcomeKind  (outcomeKind),
      .writeStrobe  (writeStrobe),
      .sdramAddr    (sdramAddr),
      .writeData    (writeData),
      .nibbleSel    (nibbleSel)
   );

   commsWatchdog #(
      .TimeoutCycles (TimeoutCycles)
   ) commsWatchdog_inst (
      .clk     (clk),
      .rst     (rst),
      .cmdOpen (cmdOpen),
      .rxValid (rxValid),
      .timeout (timeout)
   );

   // Merges parser outcomes and watchdog timeouts
   replySequencer #(
      .ErrorHoldCycles (ErrorHoldCycles)
   ) replySequencer_inst (
      .clk          (clk),
      .rst          (rst),
      .outcomeValid (outcomeValid),
      .outcomeKind  (outcomeKind),
      .timeout      (timeout),
      .sdramReady   (sdramReady),
      .txActive     (txActive),
      .txData       (txData),
      .txStart      (txStart),
      .serialError  (serialError),
      .replyBusy    (replyBusy)
   );

endmodule

//--- replySequencer.sv
// Reply sequencer and error hold
module replySequencer
   import sdramTestPkg::*;
#(
   parameter int ErrorHoldCycles = 40
)
(
   input  logic    clk,
   input  logic    rst,
   input  logic    outcomeValid,
   input  outcomeT outcomeKind,
   input  logic    timeout,
   input  logic    sdramReady,
   input  logic    txActive,
   output charT    txData,
   output logic    txStart,
   output logic    serialError,
   output logic    replyBusy
);

   localparam int HoldWidth = $clog2(ErrorHoldCycles);

   replyStateT           state;
   logic                 replyNak;
   logic                 isReady;
   charT                 firstChar;
   logic [HoldWidth-1:0] holdCount;

   charT       stepChar;
   replyStateT stepNext;
   logic       txIdle;

   assign txIdle = !txStart && !txActive;

   // Character and successor of each send step
   always_comb
   begin
      stepChar = CharLf;
      stepNext = RsIdle;
      case (state)
         RsFirst:
         begin
            stepChar = firstChar;
            stepNext = isReady ? RsCr : RsSecond;
         end
         RsSecond:
         begin
            stepChar = replyNak ? "A" : "C";
            stepNext = RsThird;
         end
         RsThird:
         begin
            stepChar = "K";
            stepNext = RsCr;
         end
         RsCr:
         begin
            stepChar = CharCr;
            stepNext = RsLf;
         end
         RsLf:
         begin
            stepChar = CharLf;
            stepNext = RsLfWait;
         end
         default:
            stepNext = RsIdle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state       <= RsIdle;
         txStart     <= 1'b0;
         serialError <= 1'b0;
         replyBusy   <= 1'b0;
      end
      else
      begin
         // UART has taken the character
         if (txStart && txActive)
            txStart <= 1'b0;
         case (state)
            RsIdle:
               if (outcomeValid || timeout)
               begin
                  replyNak  <= timeout || (outcomeKind == OutBad);
                  isReady   <= !timeout && (outcomeKind == OutReadyQuery);
                  // Ready level sampled once at reply start
                  if (!timeout && outcomeKind == OutReadyQuery)
                     firstChar <= sdramReady ? CharY : "N";
                  else
                     firstChar <= (timeout || outcomeKind == OutBad) ? "N" : "A";
                  replyBusy <= 1'b1;
                  state     <= RsFirst;
               end
            RsFirst, RsSecond, RsThird, RsCr, RsLf:
               if (txIdle)
               begin
                  txData  <= stepChar;
                  txStart <= 1'b1;
                  state   <= stepNext;
               end
            RsLfWait:
               if (txStart && txActive)
               begin
                  if (replyNak)
                  begin
                     serialError <= 1'b1;
                     holdCount   <= '0;
                     state       <= RsErrorHold;
                  end
                  else
                  begin
                     replyBusy <= 1'b0;
                     state     <= RsIdle;
                  end
               end
            RsErrorHold:
               if (holdCount == HoldWidth'(ErrorHoldCycles - 1))
               begin
                  serialError <= 1'b0;
                  replyBusy   <= 1'b0;
                  state       <= RsIdle;
               end
               else
                  holdCount <= holdCount + 1'b1;
            default:
               state <= RsIdle;
         endcase
      end
   end

   // Start only toward an idle transmitter
   startWhenIdle: assert property (@(posedge clk) disable iff (rst)
      $rose(txStart) |-> !$past(txActive));

endmodule

//--- commsWatchdog.sv
// Receive idle watchdog
module commsWatchdog
#(
   parameter int TimeoutCycles = 64
)
(
   input  logic clk,
   input  logic rst,
   input  logic cmdOpen,
   input  logic rxValid,
   output logic timeout
);

   localparam int CountWidth = $clog2(TimeoutCycles);

   logic [CountWidth-1:0] idleCount;

   // Count idle cycles of an open command
   always_ff @(posedge clk)
   begin
      if (rst || !cmdOpen || rxValid)
      begin
         idleCount <= '0;
         timeout   <= 1'b0;
      end
      else
      begin
         idleCount <= idleCount + 1'b1;
         // Pulse is registered so compare one count early
         timeout   <= (idleCount == CountWidth'(TimeoutCycles - 2));
      end
   end

   // Parser must still hold the command open when the pulse lands
   timeoutWhileOpen: assert property (@(posedge clk) disable iff (rst) timeout |-> cmdOpen);

endmodule

//--- cmdParser.sv
// Serial command parser
module cmdParser
   import sdramTestPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       rxValid,
   input  charT       rxData,
   input  logic       replyBusy,
   input  logic       timeout,
   output logic       cmdOpen,
   output logic       outcomeValid,
   output outcomeT    outcomeKind,
   output logic       writeStrobe,
   output sdramAddrT  sdramAddr,
   output dataByteT   writeData,
   output logic       nibbleSel
);

   parseStateT state;
   outcomeT    pendingKind;
   byteCountT  bytesLeft;
   nibbleT     dataHi;
   logic [2:0] addrDigits;
   logic       selArmed;
   logic       selValue;

   logic       rxAccept;
   logic       hexOk;
   nibbleT     hexNib;
   logic       isEol;
   logic       charBad;

   // Also drop the character that lands on the outcome pulse itself
   assign rxAccept = rxValid && !replyBusy && !outcomeValid;
   assign cmdOpen  = (state != PsIdle);
   assign isEol    = (rxData == CharCr) || (rxData == CharLf);

   // Hex digit decode in either case
   always_comb
   begin
      hexOk  = 1'b1;
      hexNib = rxData[3:0];
      if (rxData >= "0" && rxData <= "9")
         hexNib = rxData[3:0];
      else if ((rxData >= "A" && rxData <= "F") || (rxData >= "a" && rxData <= "f"))
         hexNib = rxData[3:0] + 4'd9;
      else
         hexOk = 1'b0;
   end

   // Character check for the field expected next
   always_comb
   begin
      case (state)
         PsIdle:
            charBad = !(rxData inside {CharW, CharS, CharY});
         PsCountHi, PsCountLo, PsAddrNib, PsDataHi, PsDataLo:
            charBad = !hexOk;
         PsComma1, PsComma2:
            charBad = (rxData != CharComma);
         PsAddrTop, PsSelDigit:
            charBad = !(rxData inside {"0", "1"});
         default:
            charBad = !isEol;
      endcase
   end

   always_ff @(posedge clk)
   begin
      writeStrobe  <= 1'b0;
      outcomeValid <= 1'b0;
      // Advance to the next byte address after each write
      if (writeStrobe)
         sdramAddr <= sdramAddr + 1'b1;
      if (rst)
      begin
         state        <= PsIdle;
         writeStrobe  <= 1'b0;
         outcomeValid <= 1'b0;
         nibbleSel    <= 1'b0;
      end
      else if (timeout)
         state <= PsIdle;
      else if (rxAccept)
      begin
         if (charBad)
         begin
            state        <= PsIdle;
            outcomeValid <= 1'b1;
            outcomeKind  <= OutBad;
         end
         else
         begin
            case (state)
               PsIdle:
               begin
                  pendingKind <= (rxData == CharY) ? OutReadyQuery : OutOk;
                  selArmed    <= (rxData == CharS);
                  if (rxData == CharW)
                     state <= PsCountHi;
                  else if (rxData == CharS)
                     state <= PsSelDigit;
                  else
                     state <= PsEol1;
               end
               PsCountHi:
               begin
                  bytesLeft[7:4] <= hexNib;
                  state          <= PsCountLo;
               end
               PsCountLo:
               begin
                  bytesLeft[3:0] <= hexNib;
                  state          <= PsComma1;
               end
               PsComma1:
                  state <= PsAddrTop;
               PsAddrTop:
               begin
                  sdramAddr[20] <= rxData[0];
                  addrDigits    <= 3'd0;
                  state         <= PsAddrNib;
               end
               PsAddrNib:
               begin
                  // Five digits shift in from the top nibble down
                  sdramAddr[19:0] <= {sdramAddr[15:0], hexNib};
                  addrDigits      <= addrDigits + 3'd1;
                  if (addrDigits == 3'd4)
                     state <= PsComma2;
               end
               PsComma2:
                  state <= PsDataHi;
               PsDataHi:
               begin
                  dataHi <= hexNib;
                  state  <= PsDataLo;
               end
               PsDataLo:
               begin
                  writeData   <= {dataHi, hexNib};
                  writeStrobe <= 1'b1;
                  if (bytesLeft == '0)
                     state <= PsEol1;
                  else
                  begin
                     bytesLeft <= bytesLeft - 1'b1;
                     state     <= PsDataHi;
                  end
               end
               PsSelDigit:
               begin
                  selValue <= rxData[0];
                  state    <= PsEol1;
               end
               PsEol1:
                  state <= PsEol2;
               PsEol2:
               begin
                  state        <= PsIdle;
                  outcomeValid <= 1'b1;
                  outcomeKind  <= pendingKind;
                  if (selArmed)
                     nibbleSel <= selValue;
               end
               default:
                  state <= PsIdle;
            endcase
         end
      end
   end

   // Writes only come out of an open write command
   writeInCommand: assert property (@(posedge clk) disable iff (rst) writeStrobe |-> cmdOpen);

endmodule

//--- sdramTestPkg.sv
// SDRAM tester shared types
package sdramTestPkg;

   // Vector types
   typedef logic [7:0]  charT;
   typedef logic [3:0]  nibbleT;
   typedef logic [20:0] sdramAddrT;
   typedef logic [7:0]  dataByteT;
   // Number of data bytes minus one
   typedef logic [7:0]  byteCountT;

   typedef enum logic [1:0] {
      OutOk,
      OutBad,
      OutReadyQuery
   } outcomeT;

   typedef enum logic [3:0] {
      PsIdle,
      PsCountHi,
      PsCountLo,
      PsComma1,
      PsAddrTop,
      PsAddrNib,
      PsComma2,
      PsDataHi,
      PsDataLo,
      PsSelDigit,
      PsEol1,
      PsEol2
   } parseStateT;

   typedef enum logic [2:0] {
      RsIdle,
      RsFirst,
      RsSecond,
      RsThird,
      RsCr,
      RsLf,
      RsLfWait,
      RsErrorHold
   } replyStateT;

   localparam charT CharCr    = 8'h0d;
   localparam charT CharLf    = 8'h0a;
   localparam charT CharComma = 8'h2c;
   localparam charT CharW     = 8'h57;
   localparam charT CharS     = 8'h53;
   localparam charT CharY     = 8'h59;

endpackage
